// ==== bg_pkg.sv ====
package bg_pkg;

	// ==============================
	// Picture memory geometry
	// ==============================

	// One 32-bit word per pixel
	localparam int PIC_WORDS = 1024;
	localparam int PIC_AW = 10;

	// Download byte address
	// bit 0 picks the byte in a half-word, bit 1 the half in a word
	localparam int DL_AW = 12;

	// Download index used for a background picture
	localparam logic [7:0] BG_INDEX = 8'd2;

	// First pixel when the picture is walked backwards
	localparam logic [PIC_AW-1:0] FLIP_START = PIC_AW'(PIC_WORDS - 1);

	// ==============================
	// Picture word
	// ==============================

	// Channel positions in the channel view, most significant first
	localparam int CH_A = 3;
	localparam int CH_B = 2;
	localparam int CH_G = 1;
	localparam int CH_R = 0;

	// Written as two half-words, read back as four colour channels
	typedef union packed
	{
		logic [1:0][15:0] half;
		logic [3:0][7:0] chan;
	} pic_word_t;

endpackage

// ==== bg_loader.sv ====
`timescale 1ns/10ps

module bg_loader
(
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       dl_active,
	input  logic [7:0]                 dl_index,
	input  logic                       dl_wr,
	input  logic [bg_pkg::DL_AW-1:0]   dl_addr,
	input  logic [7:0]                 dl_data,
	output logic                       wr_en,
	output logic [bg_pkg::PIC_AW:0]    wr_addr,
	output logic [15:0]                wr_data,
	output logic                       use_bg
);

	logic       bg_take;
	logic [7:0] lo_byte;

	// Only bytes of a background download are taken
	assign bg_take = dl_wr && dl_active && (dl_index == bg_pkg::BG_INDEX);

	// Even byte waits here for its odd partner
	always_ff @(posedge clk_sys)
	begin
		if (bg_take && !dl_addr[0])
			lo_byte <= dl_data;
	end

	// Half-word payload, formed on the odd byte
	always_ff @(posedge clk_sys)
	begin
		if (bg_take && dl_addr[0])
		begin
			wr_addr <= dl_addr[bg_pkg::DL_AW-1:1];
			wr_data <= {dl_data, lo_byte};
		end
	end

	// One-cycle write strobe and the sticky overlay enable
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			wr_en <= 1'b0;
			use_bg <= 1'b0;
		end
		else
		begin
			wr_en <= bg_take && dl_addr[0];
			if (bg_take && dl_addr[0])
				use_bg <= 1'b1;
		end
	end

endmodule

// ==== pic_ram.sv ====
`timescale 1ns/10ps

module pic_ram
(
	input  logic                        clk_sys,
	input  logic                        wr_en,
	input  logic [bg_pkg::PIC_AW:0]     wr_addr,
	input  logic [15:0]                 wr_data,
	input  logic [bg_pkg::PIC_AW-1:0]   rd_addr,
	output bg_pkg::pic_word_t           rd_data
);

	// ==============================
	// Storage
	// ==============================

	bg_pkg::pic_word_t mem [bg_pkg::PIC_WORDS];

	logic [bg_pkg::PIC_AW-1:0] wr_word;
	logic                      wr_half;

	// Upper bits pick the pixel, bit 0 picks the half
	assign wr_word = wr_addr[bg_pkg::PIC_AW:1];
	assign wr_half = wr_addr[0];

	// Half-word write port
	always_ff @(posedge clk_sys)
	begin
		if (wr_en)
			mem[wr_word].half[wr_half] <= wr_data;
	end

	// ==============================
	// Read port
	// ==============================

	// Registered word, old contents on a same-cycle write
	always_ff @(posedge clk_sys)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

// ==== bg_scanout.sv ====
`timescale 1ns/10ps

module bg_scanout
(
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        use_bg,
	input  logic                        flip,
	input  logic                        ce_pix,
	input  logic                        hblank,
	input  logic                        vblank,
	input  logic                        vsync,
	input  logic [7:0]                  fg_r,
	input  logic [7:0]                  fg_g,
	input  logic [7:0]                  fg_b,
	input  bg_pkg::pic_word_t           rd_data,
	output logic [bg_pkg::PIC_AW-1:0]   rd_addr,
	output logic [7:0]                  out_r,
	output logic [7:0]                  out_g,
	output logic [7:0]                  out_b
);

	logic [bg_pkg::PIC_AW-1:0] pix_addr;
	logic                      vs_old;
	logic                      vs_rise;
	logic                      active;
	logic [7:0]                bg_a;
	logic [7:0]                bg_b;
	logic [7:0]                bg_g;
	logic [7:0]                bg_r;
	logic                      fg_lit;
	logic                      show_fg;

	// ==============================
	// Address stepping
	// ==============================

	assign active = !hblank && !vblank;
	assign vs_rise = !vs_old && vsync;

	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			pix_addr <= '0;
			vs_old <= 1'b0;
		end
		else if (ce_pix)
		begin
			vs_old <= vsync;
			// Frame restart wins over the step
			if (vs_rise)
				pix_addr <= flip ? bg_pkg::FLIP_START : '0;
			else if (active)
				pix_addr <= flip ? pix_addr - 1'b1 : pix_addr + 1'b1;
		end
	end

	assign rd_addr = pix_addr;

	// ==============================
	// Background capture
	// ==============================

	// Word read at the address held since the previous enable
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			bg_a <= '0;
			bg_b <= '0;
			bg_g <= '0;
			bg_r <= '0;
		end
		else if (ce_pix)
		begin
			if (use_bg)
			begin
				bg_a <= rd_data.chan[bg_pkg::CH_A];
				bg_b <= rd_data.chan[bg_pkg::CH_B];
				bg_g <= rd_data.chan[bg_pkg::CH_G];
				bg_r <= rd_data.chan[bg_pkg::CH_R];
			end
			else
			begin
				// Overlay off, background stays black and transparent
				bg_a <= '0;
				bg_b <= '0;
				bg_g <= '0;
				bg_r <= '0;
			end
		end
	end

	// Foreground wins where lit, unless alpha gives the background priority
	assign fg_lit = |{fg_r, fg_g, fg_b};
	assign show_fg = fg_lit && (bg_a == 8'd0);

	assign out_r = show_fg ? fg_r : bg_r;
	assign out_g = show_fg ? fg_g : bg_g;
	assign out_b = show_fg ? fg_b : bg_b;

endmodule

// ==== bg_overlay_top.sv ====
`timescale 1ns/10ps

module bg_overlay_top
(
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       dl_active,
	input  logic [7:0]                 dl_index,
	input  logic                       dl_wr,
	input  logic [bg_pkg::DL_AW-1:0]   dl_addr,
	input  logic [7:0]                 dl_data,
	input  logic                       ce_pix,
	input  logic                       hblank,
	input  logic                       vblank,
	input  logic                       vsync,
	input  logic                       flip,
	input  logic [7:0]                 fg_r,
	input  logic [7:0]                 fg_g,
	input  logic [7:0]                 fg_b,
	output logic [7:0]                 out_r,
	output logic [7:0]                 out_g,
	output logic [7:0]                 out_b
);

	// Loader to memory
	logic                      wr_en;
	logic [bg_pkg::PIC_AW:0]   wr_addr;
	logic [15:0]               wr_data;
	logic                      use_bg;

	// Scanout to memory
	logic [bg_pkg::PIC_AW-1:0] rd_addr;
	bg_pkg::pic_word_t         rd_data;

	bg_loader bg_loader_i
	(
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_index  (dl_index),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.use_bg    (use_bg)
	);

	pic_ram pic_ram_i
	(
		.clk_sys (clk_sys),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	bg_scanout bg_scanout_i
	(
		.clk_sys (clk_sys),
		.reset   (reset),
		.use_bg  (use_bg),
		.flip    (flip),
		.ce_pix  (ce_pix),
		.hblank  (hblank),
		.vblank  (vblank),
		.vsync   (vsync),
		.fg_r    (fg_r),
		.fg_g    (fg_g),
		.fg_b    (fg_b),
		.rd_data (rd_data),
		.rd_addr (rd_addr),
		.out_r   (out_r),
		.out_g   (out_g),
		.out_b   (out_b)
	);

endmodule

// ==== bg_overlay_chk.sv ====
`timescale 1ns/10ps

module bg_overlay_chk
(
	input logic                      clk_sys,
	input logic                      reset,
	input logic [bg_pkg::DL_AW-1:0]  dl_addr,
	input logic                      wr_en,
	input logic [bg_pkg::PIC_AW:0]   wr_addr,
	input logic                      use_bg,
	input logic                      ce_pix,
	input logic [bg_pkg::PIC_AW-1:0] rd_addr
);

	// ==============================
	// Loader strobes
	// ==============================

	// Write strobe lasts a single cycle
	a_wr_single: assert property (@(posedge clk_sys) disable iff (reset) wr_en |=> !wr_en)
		else $error("loader write strobe high on two cycles in a row");

	// Overlay enable is sticky
	a_use_bg_sticky: assert property (@(posedge clk_sys) $fell(use_bg) |-> $past(reset))
		else $error("overlay enable fell outside reset");

	// Each write lands on the half-word of the odd byte that caused it
	a_wr_range: assert property (@(posedge clk_sys) disable iff (reset)
		wr_en |-> (!$isunknown(wr_addr) && wr_addr == $past(dl_addr[bg_pkg::DL_AW-1:1])))
		else $error("loader write address does not follow the download address");

	// ==============================
	// Scanout address
	// ==============================

	a_addr_on_ce: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(rd_addr) |-> $past(ce_pix))
		else $error("scanout address moved without a pixel enable");

endmodule

bind bg_overlay_top bg_overlay_chk bg_overlay_chk_i
(
	.clk_sys (clk_sys),
	.reset   (reset),
	.dl_addr (dl_addr),
	.wr_en   (wr_en),
	.wr_addr (wr_addr),
	.use_bg  (use_bg),
	.ce_pix  (ce_pix),
	.rd_addr (rd_addr)
);

// ==== tb_bg_overlay.sv ====
`timescale 1ns/10ps

module tb_bg_overlay;

	logic                     clk_sys;
	logic                     reset;
	logic                     dl_active;
	logic [7:0]               dl_index;
	logic                     dl_wr;
	logic [bg_pkg::DL_AW-1:0] dl_addr;
	logic [7:0]               dl_data;
	logic                     ce_pix;
	logic                     hblank;
	logic                     vblank;
	logic                     vsync;
	logic                     flip;
	logic [7:0]               fg_r;
	logic [7:0]               fg_g;
	logic [7:0]               fg_b;
	logic [7:0]               out_r;
	logic [7:0]               out_g;
	logic [7:0]               out_b;

	// Reference model state
	logic [31:0]               ref_mem [bg_pkg::PIC_WORDS];
	logic [7:0]                ref_lo;
	logic                      ref_use_bg;
	logic [bg_pkg::PIC_AW-1:0] ref_addr;
	logic                      ref_vs_old;
	logic [31:0]               ref_bg;

	bg_overlay_top bg_overlay_top_i (.*);

	initial
	begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	task automatic fail_stop(input string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	// Inputs change a little after the rising edge
	task automatic next_cycle;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic check_chan(input string name, input logic [7:0] exp, input logic [7:0] act);
		assert (act === exp)
		else
			fail_stop($sformatf("MISMATCH time=%0t %s expected=%02h actual=%02h",
				$time, name, exp, act));
	endtask

	task automatic apply_reset;
		reset = 1'b1;
		repeat (8) next_cycle();
		reset = 1'b0;
		ref_use_bg = 1'b0;
		ref_addr = '0;
		ref_vs_old = 1'b0;
		ref_bg = '0;
	endtask

	// ==============================
	// Download side
	// ==============================

	task automatic send_byte(input logic [7:0] idx, input logic [bg_pkg::DL_AW-1:0] addr,
		input logic [7:0] data);
		dl_index = idx;
		dl_addr = addr;
		dl_data = data;
		dl_wr = 1'b1;
		next_cycle();
		dl_wr = 1'b0;
		next_cycle();
		// Even byte waits, odd byte writes a half-word over the waiting one
		if (idx == bg_pkg::BG_INDEX && !addr[0])
			ref_lo = data;
		else if (idx == bg_pkg::BG_INDEX)
		begin
			ref_mem[addr[bg_pkg::DL_AW-1:2]][{addr[1], 4'd0} +: 16] = {data, ref_lo};
			ref_use_bg = 1'b1;
		end
	endtask

	task automatic download_picture(input logic [7:0] idx, input int halves);
		logic [bg_pkg::DL_AW-1:0] base;
		logic [7:0]               lo;
		logic [7:0]               hi;
		dl_active = 1'b1;
		for (int h = 0; h < halves; h++)
		begin
			base = bg_pkg::DL_AW'(2 * h);
			lo = 8'($urandom);
			hi = 8'($urandom);
			// Alpha sits in the top byte of the upper half
			if (base[1] && $urandom_range(1) == 0)
				hi = 8'd0;
			// First pair leads with its even byte so the latch holds real data
			if (h == 0 || $urandom_range(1) == 0)
			begin
				send_byte(idx, base, lo);
				send_byte(idx, base + 1'b1, hi);
			end
			else
			begin
				send_byte(idx, base + 1'b1, hi);
				send_byte(idx, base, lo);
			end
		end
		dl_active = 1'b0;
		next_cycle();
	endtask

	// ==============================
	// Video side
	// ==============================

	// One pixel slot is four cycles with ce_pix in the first
	task automatic pixel(input logic hb, input logic vb, input logic vs);
		logic show;
		hblank = hb;
		vblank = vb;
		vsync = vs;
		{fg_r, fg_g, fg_b} = ($urandom_range(3) == 0) ? 24'd0 : 24'($urandom);
		ce_pix = 1'b1;
		next_cycle();
		ce_pix = 1'b0;
		ref_bg = ref_use_bg ? ref_mem[ref_addr] : '0;
		if (!ref_vs_old && vsync)
			ref_addr = flip ? bg_pkg::FLIP_START : '0;
		else if (!hblank && !vblank)
			ref_addr = flip ? ref_addr - 1'b1 : ref_addr + 1'b1;
		ref_vs_old = vsync;
		#2;
		show = (|{fg_r, fg_g, fg_b}) && (ref_bg[31:24] == 8'd0);
		check_chan("out_r", show ? fg_r : ref_bg[7:0], out_r);
		check_chan("out_g", show ? fg_g : ref_bg[15:8], out_g);
		check_chan("out_b", show ? fg_b : ref_bg[23:16], out_b);
		repeat (3) next_cycle();
	endtask

	task automatic frame(input logic flip_lvl, input int restart_line, input logic restart_flip);
		flip = flip_lvl;
		// Vertical blanking with the sync pulse in its middle
		for (int px = 0; px < 12; px++)
			pixel(1'b1, 1'b1, px >= 4 && px < 8);
		for (int line = 0; line < 32; line++)
		begin
			// Extra sync pulse inside a line gap
			if (line == restart_line)
			begin
				flip = restart_flip;
				for (int px = 0; px < 4; px++)
					pixel(1'b1, 1'b0, px == 1 || px == 2);
			end
			for (int px = 0; px < 32; px++)
				pixel(1'b0, 1'b0, 1'b0);
			for (int px = 0; px < 4; px++)
				pixel(1'b1, 1'b0, 1'b0);
		end
	endtask

	initial
	begin
		void'($urandom(44));
		reset = 1'b1;
		dl_active = 1'b0;
		dl_index = 8'd0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = 8'd0;
		ce_pix = 1'b0;
		hblank = 1'b1;
		vblank = 1'b1;
		vsync = 1'b0;
		flip = 1'b0;
		{fg_r, fg_g, fg_b} = 24'd0;
		ref_lo = 8'd0;
		apply_reset();
		frame(1'b0, -1, 1'b0);
		// Bytes for another download index are ignored
		download_picture(8'd5, 64);
		assert (!bg_overlay_top_i.use_bg)
		else
			fail_stop("Overlay turned on during a download with another index");
		download_picture(bg_pkg::BG_INDEX, 2 * bg_pkg::PIC_WORDS);
		assert (bg_overlay_top_i.use_bg)
		else
			fail_stop("Overlay did not turn on after the background download");
		frame(1'b0, -1, 1'b0);
		frame(1'b0, -1, 1'b0);
		frame(1'b1, -1, 1'b1);
		frame(1'b0, 12, 1'b1);
		frame(1'b1, 20, 1'b0);
		// Reset drops the overlay until the next half-word write
		apply_reset();
		frame(1'b0, -1, 1'b0);
		download_picture(bg_pkg::BG_INDEX, 1);
		frame(1'b0, -1, 1'b0);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== flist.f ====
bg_pkg.sv
bg_loader.sv
pic_ram.sv
bg_scanout.sv
bg_overlay_top.sv
bg_overlay_chk.sv
tb_bg_overlay.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the overlay testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_bg_overlay \
	-Mdir obj_dir -o sim_bg_overlay

# The simulator status is checked through the log below
./obj_dir/sim_bg_overlay 2>&1 | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	echo "Test failed"
	exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
	echo "Test did not complete"
	exit 1
fi
echo "Test passed"
